//--- hdl/spis_proto_pkg.sv
`default_nettype none

package spis_proto_pkg;

   //////////////////////////////////////////////////
   // Command opcodes
   //////////////////////////////////////////////////
   typedef logic [7:0] opcode_t;

   localparam opcode_t OP_READ           = 8'h03; // Single lane, no dummy
   localparam opcode_t OP_FAST_READ      = 8'h0B; // Single lane, 8 dummy
   localparam opcode_t OP_QUAD_READ      = 8'h6B; // Quad data only
   localparam opcode_t OP_QUAD_IO_READ   = 8'hEB; // Quad addr and data
   localparam opcode_t OP_PAGE_PROG      = 8'h02; // Single lane write
   localparam opcode_t OP_QUAD_PAGE_PROG = 8'h32; // Quad data write

   //////////////////////////////////////////////////
   // Phases and lane widths
   //////////////////////////////////////////////////
   typedef enum logic [2:0] {
      IDLE,     // ssn high
      CMD,      // Opcode shift
      ADDR,     // 24-bit address shift
      DUMMY,    // Turnaround clocks
      WRITE,    // Write data words
      READ,     // Read data words
      WAIT_SS   // Unknown opcode, park until ssn rises
   } spis_state_t;

   typedef enum logic {
      LANE_SINGLE, // sdin[0] / sdout[0]
      LANE_QUAD    // All four lanes, lane 3 is MSB
   } lane_mode_t;

   typedef struct packed {
      logic       supported;  // Opcode known
      logic       is_read;    // Read vs write data phase
      lane_mode_t addr_mode;
      lane_mode_t data_mode;
      logic [3:0] dummy_clks; // Zero skips DUMMY
   } cmd_cfg_t;

   // Phase lengths in sclk rises
   typedef logic [5:0] bit_cnt_t;

   localparam bit_cnt_t CMD_CLKS         = 6'd8;
   localparam bit_cnt_t ADDR_CLKS_SINGLE = 6'd24;
   localparam bit_cnt_t ADDR_CLKS_QUAD   = 6'd6;
   localparam bit_cnt_t WORD_CLKS_SINGLE = 6'd32;
   localparam bit_cnt_t WORD_CLKS_QUAD   = 6'd8;

endpackage

`default_nettype wire

//--- hdl/spis_bus_pkg.sv
`default_nettype none

package spis_bus_pkg;

   typedef logic [23:0] reg_addr_t; // Byte address
   typedef logic [31:0] reg_data_t; // One register word

   // Request levels plus payload, 58 bits
   typedef struct packed {
      logic      wr;    // Held until ack
      logic      rd;    // Held until ack
      reg_addr_t addr;  // Stable while wr or rd
      reg_data_t wdata; // Stable while wr
   } reg_req_t;

   localparam reg_addr_t ADDR_STEP = 24'd4; // Burst stride

endpackage

`default_nettype wire

//--- hdl/spis_sync.sv
`timescale 1ns/1ps
`default_nettype none

module spis_sync #(
   parameter int SYNC_STAGES = 2
) (
   input  logic       sys_clk,
   input  logic       rst_n,
   input  logic       sclk,
   input  logic       ssn,
   input  logic [3:0] sdin,
   output logic       ssn_s,
   output logic [3:0] sdin_s,
   output logic       sclk_rise,
   output logic       sclk_fall
);

   logic [SYNC_STAGES:0]      sclk_q; // Extra stage for edge compare
   logic [SYNC_STAGES-1:0]    ssn_q;
   logic [SYNC_STAGES:0][3:0] sdin_q; // Same depth as the edge pulse

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         sclk_q    <= '0;   // Mode 0 idles low
         ssn_q     <= '1;   // Deselected
         sdin_q    <= '1;
         sclk_rise <= 1'b0;
         sclk_fall <= 1'b0;
      end else begin
         sclk_q    <= {sclk_q[SYNC_STAGES-1:0], sclk};
         ssn_q     <= {ssn_q[SYNC_STAGES-2:0], ssn};
         sdin_q    <= {sdin_q[SYNC_STAGES-1:0], sdin};
         sclk_rise <= sclk_q[SYNC_STAGES-1] & ~sclk_q[SYNC_STAGES]; // 0 -> 1
         sclk_fall <= ~sclk_q[SYNC_STAGES-1] & sclk_q[SYNC_STAGES]; // 1 -> 0
      end
   end

   assign ssn_s  = ssn_q[SYNC_STAGES-1];
   assign sdin_s = sdin_q[SYNC_STAGES];   // Valid in the sclk_rise cycle

endmodule

`default_nettype wire

//--- hdl/spis_bit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module spis_bit_counter (
   input  logic                     sys_clk,
   input  logic                     rst_n,
   input  logic                     cnt_load,  // From FSM at phase start
   input  spis_proto_pkg::bit_cnt_t cnt_value, // Phase length minus one
   input  logic                     sclk_rise,
   output logic                     cnt_last
);

   import spis_proto_pkg::*;

   bit_cnt_t cnt; // Rises left in this phase

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (cnt_load) begin
         cnt <= cnt_value;         // Load wins over a rise
      end else if (sclk_rise && !cnt_last) begin
         cnt <= cnt - 1'b1;        // Parks at zero until reloaded
      end
   end

   assign cnt_last = (cnt == '0);

endmodule

`default_nettype wire

//--- hdl/spis_shift_in.sv
`timescale 1ns/1ps
`default_nettype none

module spis_shift_in #(
   parameter type payload_t = logic [7:0]
) (
   input  logic                       sys_clk,
   input  logic                       rst_n,
   input  logic                       shift_en,  // sclk_rise in own phase
   input  spis_proto_pkg::lane_mode_t lane_mode,
   input  logic [3:0]                 sdin_s,
   output payload_t                   value
);

   import spis_proto_pkg::*;

   localparam int W = $bits(payload_t);

   logic [W-1:0] shreg; // MSB first

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         shreg <= '0;
      end else if (shift_en) begin
         if (lane_mode == LANE_QUAD) begin
            shreg <= {shreg[W-5:0], sdin_s};     // Lane 3 lands highest
         end else begin
            shreg <= {shreg[W-2:0], sdin_s[0]};  // Lane 0 only
         end
      end
   end

   assign value = payload_t'(shreg);

endmodule

`default_nettype wire

//--- hdl/spis_shift_out.sv
`timescale 1ns/1ps
`default_nettype none

module spis_shift_out (
   input  logic                       sys_clk,
   input  logic                       rst_n,
   input  logic                       rdata_load, // Read ack strobe
   input  spis_bus_pkg::reg_data_t    rdata,
   input  logic                       shift_en,   // sclk_fall in READ
   input  spis_proto_pkg::lane_mode_t lane_mode,
   output logic [3:0]                 sdout
);

   import spis_proto_pkg::*;
   import spis_bus_pkg::*;

   reg_data_t word_q; // Bits still to send, MSB first

   // Word register
   always_ff @(posedge sys_clk) begin
      if (rdata_load) begin
         word_q <= rdata;
      end else if (shift_en) begin
         if (lane_mode == LANE_QUAD) begin
            word_q <= {word_q[27:0], 4'b0000};
         end else begin
            word_q <= {word_q[30:0], 1'b0};
         end
      end
   end

   // Pin drivers, idle lanes high
   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         sdout <= 4'b1111;
      end else if (shift_en && !rdata_load) begin
         if (lane_mode == LANE_QUAD) begin
            sdout <= word_q[31:28];            // Nibble per fall
         end else begin
            sdout <= {3'b111, word_q[31]};     // Bit per fall on lane 0
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/spis_reg_port.sv
`timescale 1ns/1ps
`default_nettype none

module spis_reg_port (
   input  logic                    sys_clk,
   input  logic                    rst_n,
   input  logic                    addr_load, // End of address phase
   input  spis_bus_pkg::reg_addr_t addr_in,
   input  spis_bus_pkg::reg_data_t wdata_in,
   input  logic                    rd_start,
   input  logic                    wr_start,
   input  logic                    reg_ack,
   input  logic                    abort,     // ssn high
   output spis_bus_pkg::reg_req_t  reg_req,
   output logic                    rdata_load
);

   import spis_bus_pkg::*;

   logic      rd_q;
   logic      wr_q;
   reg_addr_t addr_q;  // Current burst address
   reg_data_t wdata_q;
   logic      acked;   // Ack for a live request

   assign acked = reg_ack & (rd_q | wr_q);

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_q <= 1'b0;
         wr_q <= 1'b0;
      end else if (abort) begin
         rd_q <= 1'b0;              // Deselect drops the request
         wr_q <= 1'b0;
      end else begin
         if (rd_start) begin
            rd_q <= 1'b1;           // Merges into a pending read
         end else if (acked) begin
            rd_q <= 1'b0;
         end
         if (wr_start) begin
            wr_q <= 1'b1;
         end else if (acked) begin
            wr_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (addr_load) begin
         addr_q <= addr_in;
      end else if (acked) begin
         addr_q <= addr_q + ADDR_STEP; // Next word of the burst
      end
      if (wr_start) begin
         wdata_q <= wdata_in;          // Frees the shifter for the next word
      end
   end

   assign reg_req    = '{wr: wr_q, rd: rd_q, addr: addr_q, wdata: wdata_q};
   assign rdata_load = reg_ack & rd_q; // rdata valid only now

endmodule

`default_nettype wire

//--- hdl/spis_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module spis_fsm (
   input  logic                       sys_clk,
   input  logic                       rst_n,
   input  logic                       ssn_s,
   input  logic                       sclk_rise,
   input  logic                       sclk_fall,
   input  logic                       cnt_last,
   input  spis_proto_pkg::opcode_t    opcode,
   output logic                       cnt_load,
   output spis_proto_pkg::bit_cnt_t   cnt_value,
   output logic                       cmd_shift_en,
   output logic                       addr_shift_en,
   output logic                       data_shift_en,
   output logic                       out_shift_en,
   output spis_proto_pkg::lane_mode_t addr_mode,
   output spis_proto_pkg::lane_mode_t data_mode,
   output logic                       addr_load,
   output logic                       rd_start,
   output logic                       wr_start,
   output logic                       sdout_oen
);

   import spis_proto_pkg::*;

   spis_state_t state;
   spis_state_t state_nxt;
   cmd_cfg_t    cfg;         // Held for the whole transaction
   cmd_cfg_t    cfg_lu;      // Decode of the fresh opcode
   logic        phase_done;  // Cycle after the last rise of a phase
   logic        in_phase;
   logic        enter_data;

   //////////////////////////////////////////////////
   // Opcode lookup
   //////////////////////////////////////////////////
   function automatic cmd_cfg_t decode(input opcode_t op);
      cmd_cfg_t c;
      c = '0; // Unknown opcode unsupported
      case (op)
         OP_READ:           c = '{1'b1, 1'b1, LANE_SINGLE, LANE_SINGLE, 4'd0};
         OP_FAST_READ:      c = '{1'b1, 1'b1, LANE_SINGLE, LANE_SINGLE, 4'd8};
         OP_QUAD_READ:      c = '{1'b1, 1'b1, LANE_SINGLE, LANE_QUAD, 4'd8};
         OP_QUAD_IO_READ:   c = '{1'b1, 1'b1, LANE_QUAD, LANE_QUAD, 4'd6};
         OP_PAGE_PROG:      c = '{1'b1, 1'b0, LANE_SINGLE, LANE_SINGLE, 4'd0};
         OP_QUAD_PAGE_PROG: c = '{1'b1, 1'b0, LANE_SINGLE, LANE_QUAD, 4'd0};
         default:           c = '0;
      endcase
      return c;
   endfunction

   // Counter preload is length minus one
   function automatic bit_cnt_t last_of(input bit_cnt_t n);
      return n - 1'b1;
   endfunction

   assign cfg_lu    = decode(opcode);
   assign in_phase  = state inside {CMD, ADDR, DUMMY, READ, WRITE};
   assign addr_mode = cfg.addr_mode;
   assign data_mode = cfg.data_mode;

   assign cmd_shift_en  = sclk_rise & (state == CMD);
   assign addr_shift_en = sclk_rise & (state == ADDR);
   assign data_shift_en = sclk_rise & (state == WRITE);
   assign out_shift_en  = sclk_fall & (state == READ); // Mode 0 drives on fall

   //////////////////////////////////////////////////
   // Next state and strobes
   //////////////////////////////////////////////////
   always_comb begin
      state_nxt  = state;
      cnt_load   = 1'b0;
      cnt_value  = '0;
      addr_load  = 1'b0;
      rd_start   = 1'b0;
      wr_start   = 1'b0;
      enter_data = 1'b0;
      if (ssn_s) begin
         state_nxt = IDLE;                      // Deselect ends any phase
      end else begin
         case (state)
            IDLE: begin
               state_nxt = CMD;
               cnt_load  = 1'b1;
               cnt_value = last_of(CMD_CLKS);
            end
            CMD: begin
               if (phase_done && cfg_lu.supported) begin
                  state_nxt = ADDR;
                  cnt_load  = 1'b1;
                  cnt_value = (cfg_lu.addr_mode == LANE_QUAD) ? last_of(ADDR_CLKS_QUAD)
                                                              : last_of(ADDR_CLKS_SINGLE);
               end else if (phase_done) begin
                  state_nxt = WAIT_SS;           // No bus access
               end
            end
            ADDR: begin
               if (phase_done) begin
                  addr_load = 1'b1;
                  if (cfg.dummy_clks != 4'd0) begin
                     state_nxt = DUMMY;
                     cnt_load  = 1'b1;
                     cnt_value = last_of(bit_cnt_t'(cfg.dummy_clks));
                  end else begin
                     enter_data = 1'b1;
                  end
               end
            end
            DUMMY: enter_data = phase_done;
            READ: begin
               rd_start  = phase_done;           // Prefetch next word
               cnt_load  = phase_done;
               cnt_value = (cfg.data_mode == LANE_QUAD) ? last_of(WORD_CLKS_QUAD)
                                                        : last_of(WORD_CLKS_SINGLE);
            end
            WRITE: begin
               wr_start  = phase_done;           // Word complete
               cnt_load  = phase_done;
               cnt_value = (cfg.data_mode == LANE_QUAD) ? last_of(WORD_CLKS_QUAD)
                                                        : last_of(WORD_CLKS_SINGLE);
            end
            WAIT_SS: state_nxt = WAIT_SS;
            default: state_nxt = IDLE;
         endcase
         if (enter_data) begin
            if (cfg.is_read) begin
               state_nxt = READ;
               rd_start  = 1'b1;                 // First word fetch
            end else begin
               state_nxt = WRITE;
            end
            cnt_load  = 1'b1;
            cnt_value = (cfg.data_mode == LANE_QUAD) ? last_of(WORD_CLKS_QUAD)
                                                     : last_of(WORD_CLKS_SINGLE);
         end
      end
   end

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= IDLE;
         cfg        <= '0;
         phase_done <= 1'b0;
         sdout_oen  <= 1'b1;
      end else begin
         state      <= state_nxt;
         phase_done <= sclk_rise & cnt_last & in_phase & ~ssn_s;
         if (state == CMD && phase_done) begin
            cfg <= cfg_lu;                       // Opcode complete here
         end
         if (state_nxt == IDLE) begin
            sdout_oen <= 1'b1;                   // Release lanes
         end else if (rd_start) begin
            sdout_oen <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/qspis_top.sv
`timescale 1ns/1ps
`default_nettype none

module qspis_top #(
   parameter int SYNC_STAGES = 2
) (
   input  logic                    sys_clk,
   input  logic                    rst_n,
   input  logic                    sclk,
   input  logic                    ssn,
   input  logic [3:0]              sdin,
   output logic [3:0]              sdout,
   output logic                    sdout_oen,  // Active low
   output spis_bus_pkg::reg_req_t  reg_req,
   input  spis_bus_pkg::reg_data_t reg_rdata,
   input  logic                    reg_ack
);

   import spis_proto_pkg::*;
   import spis_bus_pkg::*;

   logic       ssn_s;
   logic [3:0] sdin_s;
   logic       sclk_rise;
   logic       sclk_fall;
   logic       cnt_load;
   bit_cnt_t   cnt_value;
   logic       cnt_last;
   logic       cmd_shift_en;
   logic       addr_shift_en;
   logic       data_shift_en;
   logic       out_shift_en;
   lane_mode_t addr_mode;
   lane_mode_t data_mode;
   logic       addr_load;
   logic       rd_start;
   logic       wr_start;
   logic       rdata_load;
   opcode_t    opcode;
   reg_addr_t  addr_word;   // Shifted-in start address
   reg_data_t  wdata_word;  // Shifted-in write word

   //////////////////////////////////////////////////
   // Front end and control
   //////////////////////////////////////////////////
   spis_sync #(.SYNC_STAGES(SYNC_STAGES)) u_sync (
      .sys_clk, .rst_n, .sclk, .ssn, .sdin,
      .ssn_s, .sdin_s, .sclk_rise, .sclk_fall
   );

   spis_fsm u_fsm (
      .sys_clk, .rst_n, .ssn_s, .sclk_rise, .sclk_fall, .cnt_last, .opcode,
      .cnt_load, .cnt_value, .cmd_shift_en, .addr_shift_en, .data_shift_en,
      .out_shift_en, .addr_mode, .data_mode, .addr_load, .rd_start, .wr_start,
      .sdout_oen
   );

   spis_bit_counter u_cnt (
      .sys_clk, .rst_n, .cnt_load, .cnt_value, .sclk_rise, .cnt_last
   );

   //////////////////////////////////////////////////
   // Data path
   //////////////////////////////////////////////////
   spis_shift_in #(.payload_t(opcode_t)) u_cmd_in (
      .sys_clk, .rst_n, .shift_en(cmd_shift_en), .lane_mode(LANE_SINGLE),
      .sdin_s, .value(opcode)
   );

   spis_shift_in #(.payload_t(reg_addr_t)) u_addr_in (
      .sys_clk, .rst_n, .shift_en(addr_shift_en), .lane_mode(addr_mode),
      .sdin_s, .value(addr_word)
   );

   spis_shift_in #(.payload_t(reg_data_t)) u_wdata_in (
      .sys_clk, .rst_n, .shift_en(data_shift_en), .lane_mode(data_mode),
      .sdin_s, .value(wdata_word)
   );

   spis_shift_out u_rdata_out (
      .sys_clk, .rst_n, .rdata_load, .rdata(reg_rdata), .shift_en(out_shift_en),
      .lane_mode(data_mode), .sdout
   );

   spis_reg_port u_reg_port (
      .sys_clk, .rst_n, .addr_load, .addr_in(addr_word), .wdata_in(wdata_word),
      .rd_start, .wr_start, .reg_ack, .abort(ssn_s), .reg_req, .rdata_load
   );

endmodule

`default_nettype wire

//--- verif/tb_qspis.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qspis;

   import spis_proto_pkg::*;
   import spis_bus_pkg::*;

   localparam int        HALF_CLKS = 4;             // sys_clk cycles per sclk level
   localparam reg_data_t MODEL_KEY = 32'hA5C3_0F1E; // Read data pattern

   logic       sys_clk   = 1'b0;
   logic       rst_n     = 1'b0;
   logic       sclk      = 1'b0;  // Mode 0 idles low
   logic       ssn       = 1'b1;
   logic [3:0] sdin      = 4'hF;
   logic [3:0] sdout;
   logic       sdout_oen;
   reg_req_t   reg_req;
   reg_data_t  reg_rdata = '0;
   logic       reg_ack   = 1'b0;

   integer     seed = 63;
   int         errors;
   int         checks;
   int         tests;
   int         failed_tests;
   int         test_errs;     // Error count when the test began
   string      cur_test;

   reg_addr_t  rd_log[$];     // Acked read addresses
   reg_addr_t  wr_addr_log[$];
   reg_data_t  wr_data_log[$];
   logic       req_seen;
   logic [2:0] ack_wait;

   qspis_top #(.SYNC_STAGES(2)) i_dut (
      .sys_clk, .rst_n, .sclk, .ssn, .sdin, .sdout, .sdout_oen,
      .reg_req, .reg_rdata, .reg_ack
   );

   always #5 sys_clk = ~sys_clk;

   // Read data the bus returns for an address
   function automatic reg_data_t model_data(input reg_addr_t a);
      return {8'h00, a} ^ MODEL_KEY;
   endfunction

   //////////////////////////////////////////////////
   // Register bus responder
   //////////////////////////////////////////////////
   always @(posedge sys_clk) begin
      if (!rst_n) begin
         reg_ack  <= 1'b0;
         req_seen <= 1'b0;
         ack_wait <= '0;
      end else begin
         reg_ack <= 1'b0;
         if (reg_ack || !(reg_req.rd || reg_req.wr)) begin
            req_seen <= 1'b0;                             // Idle or just acked
         end else if (!req_seen) begin
            req_seen <= 1'b1;
            ack_wait <= 3'(1 + ($random(seed) & 3));      // 1 to 4 cycles
         end else if (ack_wait > 3'd1) begin
            ack_wait <= ack_wait - 3'd1;
         end else begin
            reg_ack <= 1'b1;
            if (reg_req.rd) begin
               rd_log.push_back(reg_req.addr);
               reg_rdata <= model_data(reg_req.addr);    // Valid in ack cycle
            end else begin
               wr_addr_log.push_back(reg_req.addr);
               wr_data_log.push_back(reg_req.wdata);
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////
   task automatic check_addr(input reg_addr_t exp, input reg_addr_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s: expected %h actual %h", cur_test, exp, act);
      end
   endtask

   task automatic check_data(input reg_data_t exp, input reg_data_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s: expected %h actual %h", cur_test, exp, act);
      end
   endtask

   task automatic check_bit(input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s: expected %b actual %b", cur_test, exp, act);
      end
   endtask

   task automatic check_count(input int exp, input int act);
      checks++;
      if (act != exp) begin
         errors++;
         $display("mismatch %s: expected %0d actual %0d", cur_test, exp, act);
      end
   endtask

   // Until the bus has acked this many reads and writes
   task automatic wait_acks(input int nrd, input int nwr);
      int t;
      t = 0;
      while ((rd_log.size() < nrd || wr_addr_log.size() < nwr) && t < 200) begin
         @(negedge sys_clk);
         t++;
      end
      if (rd_log.size() < nrd || wr_addr_log.size() < nwr) begin
         errors++;
         $display("%s: timed out waiting for register bus accesses", cur_test);
      end
   endtask

   //////////////////////////////////////////////////
   // SPI host, mode 0
   //////////////////////////////////////////////////
   // Fall with new data, rise, sample sdout late in the high half
   task automatic sclk_cycle(input logic [3:0] dout, output logic [3:0] din);
      @(posedge sys_clk);
      sclk <= 1'b0;
      sdin <= dout;
      repeat (HALF_CLKS) @(posedge sys_clk);
      sclk <= 1'b1;
      repeat (HALF_CLKS - 1) @(posedge sys_clk);
      @(negedge sys_clk);
      din = sdout;
   endtask

   // MSB first, a bit or a nibble per clock
   task automatic shift_word(input reg_data_t tx, input int nclk, input logic quad,
                             output reg_data_t rx);
      logic [3:0] din;
      rx = '0;
      for (int i = nclk - 1; i >= 0; i--) begin
         if (quad) begin
            sclk_cycle(tx[4*i +: 4], din);
            rx = {rx[27:0], din};
         end else begin
            sclk_cycle({3'b111, tx[i]}, din);
            rx = {rx[30:0], din[0]};
         end
      end
   endtask

   task automatic select_slave();
      @(posedge sys_clk);
      ssn <= 1'b0;
      repeat (HALF_CLKS) @(posedge sys_clk);
   endtask

   task automatic deselect_slave();
      int t;
      @(posedge sys_clk);
      sclk <= 1'b0;
      repeat (HALF_CLKS) @(posedge sys_clk);
      ssn <= 1'b1;
      t = 0;
      @(negedge sys_clk);
      while ((sdout_oen !== 1'b1 || reg_req.rd || reg_req.wr) && t < 100) begin
         @(negedge sys_clk);
         t++;
      end
      if (t >= 100) begin
         errors++;
         $display("%s: slave kept sdout enabled or a request after ssn rose", cur_test);
      end
      repeat (HALF_CLKS) @(posedge sys_clk);
   endtask

   //////////////////////////////////////////////////
   // Transactions
   //////////////////////////////////////////////////
   task automatic do_read(input opcode_t op, input reg_addr_t addr, input int nwords,
                          input logic quad_addr, input logic quad_data, input int dummy);
      int        rd_base;
      reg_data_t rx;
      rd_base = rd_log.size();
      select_slave();
      shift_word(reg_data_t'(op), 8, 1'b0, rx);
      shift_word(reg_data_t'(addr), quad_addr ? 6 : 24, quad_addr, rx);
      repeat (dummy) shift_word('1, 1, 1'b1, rx);
      for (int w = 0; w < nwords; w++) begin
         wait_acks(rd_base + w + 1, wr_addr_log.size()); // Word fetched, sclk held high
         shift_word('1, quad_data ? 8 : 32, quad_data, rx);
         check_data(model_data(addr + reg_addr_t'(4 * w)), rx);
         if (!quad_data) begin
            check_bit(1'b1, &sdout[3:1]);                // Unused lanes high
         end
      end
      wait_acks(rd_base + nwords + 1, wr_addr_log.size()); // Prefetch after last word
      check_bit(1'b0, sdout_oen);
      deselect_slave();
      check_count(rd_base + nwords + 1, rd_log.size());
      if (rd_log.size() == rd_base + nwords + 1) begin
         for (int w = 0; w <= nwords; w++) begin
            check_addr(addr + reg_addr_t'(4 * w), rd_log[rd_base + w]);
         end
      end
   endtask

   task automatic do_write(input opcode_t op, input reg_addr_t addr, input reg_data_t w0,
                           input reg_data_t w1, input logic quad_data);
      int        wr_base;
      reg_data_t rx;
      wr_base = wr_addr_log.size();
      select_slave();
      shift_word(reg_data_t'(op), 8, 1'b0, rx);
      shift_word(reg_data_t'(addr), 24, 1'b0, rx);
      shift_word(w0, quad_data ? 8 : 32, quad_data, rx);
      shift_word(w1, quad_data ? 8 : 32, quad_data, rx);
      wait_acks(rd_log.size(), wr_base + 2); // Last write must land before ssn rises
      deselect_slave();
      check_count(wr_base + 2, wr_addr_log.size());
      if (wr_addr_log.size() == wr_base + 2) begin
         check_addr(addr, wr_addr_log[wr_base]);
         check_data(w0, wr_data_log[wr_base]);
         check_addr(addr + 24'd4, wr_addr_log[wr_base + 1]);
         check_data(w1, wr_data_log[wr_base + 1]);
      end
   endtask

   task automatic begin_test(input string name);
      cur_test  = name;
      test_errs = errors;
   endtask

   task automatic end_test();
      tests++;
      if (errors == test_errs) begin
         $display("test %s ok", cur_test);
      end else begin
         failed_tests++;
         $display("test %s failed with %0d errors", cur_test, errors - test_errs);
      end
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////
   task automatic test_reset_idle();
      reg_data_t rx;
      begin_test("reset_idle");
      @(negedge sys_clk);
      check_bit(1'b1, sdout_oen);
      check_data(32'hF, reg_data_t'(sdout));
      check_bit(1'b0, reg_req.rd);
      check_bit(1'b0, reg_req.wr);
      shift_word(32'h0000_5A3C, 16, 1'b0, rx); // ssn stays high
      repeat (8) @(negedge sys_clk);
      check_count(0, rd_log.size() + wr_addr_log.size());
      check_bit(1'b1, sdout_oen);
      end_test();
   endtask

   task automatic test_quad_writes();
      reg_data_t w0;
      reg_data_t w1;
      @(negedge sys_clk);
      w0 = $random(seed);
      w1 = $random(seed);
      begin_test("page_write");
      do_write(OP_PAGE_PROG, 24'h000800, w0, w1, 1'b0);
      end_test();
      w0 = $random(seed);
      w1 = $random(seed);
      begin_test("quad_page_write");
      do_write(OP_QUAD_PAGE_PROG, 24'h001000, w0, w1, 1'b1);
      end_test();
   endtask

   task automatic test_unsupported();
      int        nrd;
      int        nwr;
      reg_data_t rx;
      begin_test("unsupported_op");
      nrd = rd_log.size();
      nwr = wr_addr_log.size();
      select_slave();
      shift_word(32'h9F, 8, 1'b0, rx);
      shift_word(32'h0123_4567, 32, 1'b0, rx);
      shift_word(32'h89, 8, 1'b0, rx);
      check_bit(1'b1, sdout_oen);
      deselect_slave();
      check_count(nrd, rd_log.size());
      check_count(nwr, wr_addr_log.size());
      end_test();
   endtask

   task automatic test_abort_recover();
      int        nrd;
      reg_data_t rx;
      begin_test("abort_recover");
      nrd = rd_log.size();
      select_slave();
      shift_word(reg_data_t'(OP_READ), 8, 1'b0, rx);
      shift_word(32'h0000_0300, 24, 1'b0, rx);
      wait_acks(nrd + 1, wr_addr_log.size());
      shift_word('1, 10, 1'b0, rx);             // Cut short mid word
      deselect_slave();
      check_bit(1'b0, reg_req.rd);
      check_count(nrd + 1, rd_log.size());
      do_read(OP_FAST_READ, 24'h000500, 1, 1'b0, 1'b0, 8);
      end_test();
   endtask

   initial begin
      errors       = 0;
      checks       = 0;
      tests        = 0;
      failed_tests = 0;
      repeat (10) @(posedge sys_clk);
      rst_n <= 1'b1;
      repeat (4) @(posedge sys_clk);

      test_reset_idle();
      begin_test("read");
      do_read(OP_READ, 24'h000100, 2, 1'b0, 1'b0, 0);
      end_test();
      begin_test("fast_reads");
      do_read(OP_FAST_READ, 24'h000200, 2, 1'b0, 1'b0, 8);
      do_read(OP_QUAD_READ, 24'h000400, 2, 1'b0, 1'b1, 8);
      do_read(OP_QUAD_IO_READ, 24'h012340, 2, 1'b1, 1'b1, 6);
      end_test();
      test_quad_writes();
      test_unsupported();
      test_abort_recover();

      $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
               tests, failed_tests, checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
hdl/spis_proto_pkg.sv
hdl/spis_bus_pkg.sv
hdl/spis_sync.sv
hdl/spis_bit_counter.sv
hdl/spis_shift_in.sv
hdl/spis_shift_out.sv
hdl/spis_reg_port.sv
hdl/spis_fsm.sv
hdl/qspis_top.sv
verif/tb_qspis.sv

//--- run_sim.sh
#!/bin/sh
# Build the QSPI slave testbench with Verilator, run it, grade the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_qspis -f sim.f -o tb_qspis
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_qspis > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
   exit 0
fi
echo "Pass line not found in $LOG"
exit 1
